// File: hdl/snp_pkg.sv
`default_nettype none

package snp_pkg;

   //////////////////////////////////////////////////////////////////////
   // stream and request encodings
   //////////////////////////////////////////////////////////////////////

   // one word of the snoop request stream
   typedef logic [31:0] word_t;

   // request type, carried in hdr1[31:30]
   typedef enum logic [1:0] {
      RQ_RD   = 2'd0,
      RQ_WR8  = 2'd1,
      RQ_WR64 = 2'd2
   } rq_type_t;

   // rdma write buffer line and word index
   typedef logic [1:0] wline_t;
   typedef logic [3:0] widx_t;

   // word counter of the request being received
   typedef logic [4:0] iq_cnt_t;

   //////////////////////////////////////////////////////////////////////
   // counter limits and buffer geometry
   //////////////////////////////////////////////////////////////////////

   // hdr1, hdr2, data1, data2
   localparam iq_cnt_t CNT_SHORT_LAST = 5'd3;
   // hdr1, hdr2, then sixteen data words
   localparam iq_cnt_t CNT_WR64_LAST  = 5'd17;

   localparam int WBUF_LINES = 4;
   localparam int WBUF_WORDS = 16;

endpackage

`default_nettype wire

// File: hdl/snp_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface snp_wr_if import snp_pkg::*; ();

   // write strobes, one per entry and field
   logic  hdr1_wen0;
   logic  hdr2_wen0;
   logic  data1_wen0;
   logic  data2_wen0;
   logic  hdr1_wen1;
   logic  hdr2_wen1;
   logic  data1_wen1;
   logic  data2_wen1;
   // stream word, one cycle behind the input
   word_t word_s0;
   // hdr1 just written is a WR64
   logic  rq_winv_s1;

   modport ctl (
      output hdr1_wen0, hdr2_wen0, data1_wen0, data2_wen0,
      output hdr1_wen1, hdr2_wen1, data1_wen1, data2_wen1,
      output word_s0,
      input  rq_winv_s1
   );

   modport iq (
      input  hdr1_wen0, hdr2_wen0, data1_wen0, data2_wen0,
      input  hdr1_wen1, hdr2_wen1, data1_wen1, data2_wen1,
      input  word_s0,
      output rq_winv_s1
   );

endinterface

`default_nettype wire

// File: hdl/snp_iq_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module snp_iq_ctl
   import snp_pkg::*;
(
   input  wire         rclk,
   input  wire         rst_n,
   input  wire         req_vld,
   input  wire word_t  req_word,
   input  wire         snpsel,
   input  wire wline_t wr_entry_s1,
   snp_wr_if.ctl       wr,
   output logic [1:0]  snpq_valid,
   output logic        rd_ptr,
   output wline_t      head_wline,
   output logic        rdmatag_wr_en_s2,
   output logic [15:0] rdma_wren_s2,
   output wline_t      rdma_wrwl_s2
);

   logic        req_vld_s0;
   iq_cnt_t     cnt;
   logic        cnt_rst;
   logic        winv_active_s2;
   logic        wr_ptr;
   logic [15:0] wen_s1;
   logic [15:0] wen_s2;
   wline_t      entry_s2;
   wline_t      entry_s2_d1;
   wline_t      entry_line [2];

   //////////////////////////////////////////////////////////////////////
   // s0 staging and word counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         req_vld_s0 <= 1'b0;
      end else begin
         req_vld_s0 <= req_vld;
      end
   end

   // word travels with the strobe into s0
   always_ff @(posedge rclk) begin
      wr.word_s0 <= req_word;
   end

   // last word of a short request or of a WR64
   assign cnt_rst = (winv_active_s2 && (cnt == CNT_WR64_LAST)) ||
                    (!winv_active_s2 && (cnt == CNT_SHORT_LAST));

   // idle at 0, starts on the strobe, runs without gaps to the last word
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (cnt_rst) begin
         cnt <= '0;
      end else if ((cnt != '0) || req_vld_s0) begin
         cnt <= cnt + 1'b1;
      end
   end

   // hdr1 type is known at count 1, holds until the next request's count 1
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         winv_active_s2 <= 1'b0;
      end else if (cnt == iq_cnt_t'(1)) begin
         winv_active_s2 <= wr.rq_winv_s1;
      end
   end

   // write pointer starts at entry 1, flips when a request completes
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= 1'b1;
      end else if (cnt_rst) begin
         wr_ptr <= ~wr_ptr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // queue write enables, entry x field
   //////////////////////////////////////////////////////////////////////

   assign wr.hdr1_wen0  = !wr_ptr && (cnt == iq_cnt_t'(0)) && req_vld_s0;
   assign wr.hdr2_wen0  = !wr_ptr && (cnt == iq_cnt_t'(1));
   assign wr.data1_wen0 = !wr_ptr && (cnt == iq_cnt_t'(2));
   assign wr.data2_wen0 = !wr_ptr && (cnt == iq_cnt_t'(3));

   assign wr.hdr1_wen1  = wr_ptr && (cnt == iq_cnt_t'(0)) && req_vld_s0;
   assign wr.hdr2_wen1  = wr_ptr && (cnt == iq_cnt_t'(1));
   assign wr.data1_wen1 = wr_ptr && (cnt == iq_cnt_t'(2));
   assign wr.data2_wen1 = wr_ptr && (cnt == iq_cnt_t'(3));

   //////////////////////////////////////////////////////////////////////
   // rdma tag and data buffer enables
   //////////////////////////////////////////////////////////////////////

   // line allocated while hdr2 is in s1
   assign rdmatag_wr_en_s2 = winv_active_s2 && (cnt == iq_cnt_t'(2));

   // decoded one cycle early, data word k sits in s0 at count k+2
   always_comb begin
      for (int k = 0; k < 16; k++) begin
         wen_s1[k] = (cnt == iq_cnt_t'(k + 1));
      end
   end

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         wen_s2 <= '0;
      end else begin
         wen_s2 <= wen_s1;
      end
   end

   // short requests never touch the buffer
   assign rdma_wren_s2 = wen_s2 & {16{winv_active_s2}};

   always_ff @(posedge rclk) begin
      entry_s2 <= wr_entry_s1;
   end

   // new line on the tag write, held for the remaining data words
   assign rdma_wrwl_s2 = rdmatag_wr_en_s2 ? entry_s2 : entry_s2_d1;

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         entry_s2_d1 <= '0;
      end else begin
         entry_s2_d1 <= rdma_wrwl_s2;
      end
   end

   // line owned by each queue entry, read at the head for freeing
   always_ff @(posedge rclk) begin
      if (rdmatag_wr_en_s2) begin
         entry_line[wr_ptr] <= entry_s2;
      end
   end

   assign head_wline = entry_line[rd_ptr];

   //////////////////////////////////////////////////////////////////////
   // valid bits and read pointer
   //////////////////////////////////////////////////////////////////////

   // set when the last word is written, cleared on issue
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         snpq_valid <= '0;
      end else begin
         snpq_valid[0] <= (snpq_valid[0] || (!wr_ptr && cnt_rst)) && !(!rd_ptr && snpsel);
         snpq_valid[1] <= (snpq_valid[1] || (wr_ptr && cnt_rst)) && !(rd_ptr && snpsel);
      end
   end

   // fifo order, starts at entry 1 like the write side
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= 1'b1;
      end else if (snpsel) begin
         rd_ptr <= ~rd_ptr;
      end
   end

endmodule

`default_nettype wire

// File: hdl/snp_iq_data.sv
`timescale 1ns/1ps
`default_nettype none

module snp_iq_data
   import snp_pkg::*;
(
   input  wire   rclk,
   input  wire   rst_n,
   snp_wr_if.iq  wr,
   input  wire   rd_ptr,
   output word_t head_hdr1,
   output word_t head_hdr2,
   output word_t head_data1,
   output word_t head_data2
);

   word_t hdr1  [2];
   word_t hdr2  [2];
   word_t data1 [2];
   word_t data2 [2];

   // two entries, each field written by its own strobe
   always_ff @(posedge rclk) begin
      if (wr.hdr1_wen0) begin
         hdr1[0] <= wr.word_s0;
      end
      if (wr.hdr2_wen0) begin
         hdr2[0] <= wr.word_s0;
      end
      if (wr.data1_wen0) begin
         data1[0] <= wr.word_s0;
      end
      if (wr.data2_wen0) begin
         data2[0] <= wr.word_s0;
      end
      if (wr.hdr1_wen1) begin
         hdr1[1] <= wr.word_s0;
      end
      if (wr.hdr2_wen1) begin
         hdr2[1] <= wr.word_s0;
      end
      if (wr.data1_wen1) begin
         data1[1] <= wr.word_s0;
      end
      if (wr.data2_wen1) begin
         data2[1] <= wr.word_s0;
      end
   end

   // type of the hdr1 being written, ready for the count 1 capture
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         wr.rq_winv_s1 <= 1'b0;
      end else if (wr.hdr1_wen0 || wr.hdr1_wen1) begin
         wr.rq_winv_s1 <= (wr.word_s0[31:30] == RQ_WR64);
      end
   end

   // head of the queue
   assign head_hdr1  = hdr1[rd_ptr];
   assign head_hdr2  = hdr2[rd_ptr];
   assign head_data1 = data1[rd_ptr];
   assign head_data2 = data2[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/rdma_tag.sv
`timescale 1ns/1ps
`default_nettype none

module rdma_tag
   import snp_pkg::*;
(
   input  wire         rclk,
   input  wire         rst_n,
   input  wire         tag_wr_en,
   output wline_t      wr_entry_s1,
   input  wire         free_en,
   input  wire wline_t free_line
);

   logic [WBUF_LINES-1:0] used;
   wline_t                alloc_s2;

   // lowest free line, offered every cycle
   always_comb begin
      wr_entry_s1 = '0;
      for (int i = WBUF_LINES - 1; i >= 0; i--) begin
         if (!used[i]) begin
            wr_entry_s1 = wline_t'(i);
         end
      end
   end

   // the line the control stage staged one cycle ago,
   // so a free in between cannot split tag and data
   always_ff @(posedge rclk) begin
      alloc_s2 <= wr_entry_s1;
   end

   // allocate on the tag write, release when the WR64 issues
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         used <= '0;
      end else begin
         if (free_en) begin
            used[free_line] <= 1'b0;
         end
         if (tag_wr_en) begin
            used[alloc_s2] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/rdma_wbuf.sv
`timescale 1ns/1ps
`default_nettype none

module rdma_wbuf
   import snp_pkg::*;
(
   input  wire                  rclk,
   input  wire [WBUF_WORDS-1:0] wren,
   input  wire wline_t          wrwl,
   input  wire word_t           wdata,
   input  wire wline_t          rd_line,
   input  wire widx_t           rd_idx,
   output word_t               rd_data
);

   // four lines of sixteen words
   word_t mem [WBUF_LINES][WBUF_WORDS];

   //////////////////////////////////////////////////////////////////////
   // write port, one enable per word index
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      for (int k = 0; k < WBUF_WORDS; k++) begin
         if (wren[k]) begin
            mem[wrwl][k] <= wdata;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read port
   //////////////////////////////////////////////////////////////////////

   // combinational, line and word chosen from outside
   assign rd_data = mem[rd_line][rd_idx];

endmodule

`default_nettype wire

// File: hdl/snp_issue.sv
`timescale 1ns/1ps
`default_nettype none

module snp_issue
   import snp_pkg::*;
(
   input  wire         rclk,
   input  wire         rst_n,
   input  wire [1:0]   snpq_valid,
   input  wire         rd_ptr,
   input  wire         issue_stall,
   input  wire word_t  head_hdr1,
   input  wire word_t  head_hdr2,
   input  wire word_t  head_data1,
   input  wire word_t  head_data2,
   input  wire wline_t head_wline,
   output logic        snpsel,
   output logic        free_en,
   output wline_t      free_line,
   output logic        iss_vld,
   output word_t       iss_hdr1,
   output word_t       iss_hdr2,
   output word_t       iss_data1,
   output word_t       iss_data2,
   output wline_t      iss_wline
);

   // head goes whenever it is complete and the pipe is free
   assign snpsel = snpq_valid[rd_ptr] && !issue_stall;

   // a WR64 hands its buffer line back as it leaves the queue
   assign free_en   = snpsel && (head_hdr1[31:30] == RQ_WR64);
   assign free_line = head_wline;

   //////////////////////////////////////////////////////////////////////
   // c1 outputs, one cycle after the select
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         iss_vld <= 1'b0;
      end else begin
         iss_vld <= snpsel;
      end
   end

   always_ff @(posedge rclk) begin
      if (snpsel) begin
         iss_hdr1  <= head_hdr1;
         iss_hdr2  <= head_hdr2;
         iss_data1 <= head_data1;
         iss_data2 <= head_data2;
         iss_wline <= head_wline;
      end
   end

endmodule

`default_nettype wire

// File: hdl/snoop_top.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_top
   import snp_pkg::*;
(
   input  wire         rclk,
   input  wire         rst_n,
   input  wire         req_vld,
   input  wire word_t  req_word,
   input  wire         issue_stall,
   input  wire wline_t rd_line,
   input  wire widx_t  rd_idx,
   output logic        iq_dequeue,
   output logic        iss_vld,
   output word_t       iss_hdr1,
   output word_t       iss_hdr2,
   output word_t       iss_data1,
   output word_t       iss_data2,
   output wline_t      iss_wline,
   output word_t       rd_data
);

   wline_t      wr_entry_s1;
   logic [1:0]  snpq_valid;
   logic        rd_ptr;
   wline_t      head_wline;
   logic        tag_wr_en;
   logic [15:0] rdma_wren;
   wline_t      rdma_wrwl;
   word_t       head_hdr1;
   word_t       head_hdr2;
   word_t       head_data1;
   word_t       head_data2;
   logic        free_en;
   wline_t      free_line;

   // control to queue stage write path
   snp_wr_if wr_if ();

   //////////////////////////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////////////////////////

   snp_iq_ctl ctl_inst (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .req_vld          (req_vld),
      .req_word         (req_word),
      .snpsel           (iq_dequeue),
      .wr_entry_s1      (wr_entry_s1),
      .wr               (wr_if.ctl),
      .snpq_valid       (snpq_valid),
      .rd_ptr           (rd_ptr),
      .head_wline       (head_wline),
      .rdmatag_wr_en_s2 (tag_wr_en),
      .rdma_wren_s2     (rdma_wren),
      .rdma_wrwl_s2     (rdma_wrwl)
   );

   snp_iq_data iq_inst (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .wr         (wr_if.iq),
      .rd_ptr     (rd_ptr),
      .head_hdr1  (head_hdr1),
      .head_hdr2  (head_hdr2),
      .head_data1 (head_data1),
      .head_data2 (head_data2)
   );

   rdma_tag tag_inst (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .tag_wr_en   (tag_wr_en),
      .wr_entry_s1 (wr_entry_s1),
      .free_en     (free_en),
      .free_line   (free_line)
   );

   // WR64 data comes straight off the staged stream word
   rdma_wbuf wbuf_inst (
      .rclk    (rclk),
      .wren    (rdma_wren),
      .wrwl    (rdma_wrwl),
      .wdata   (wr_if.word_s0),
      .rd_line (rd_line),
      .rd_idx  (rd_idx),
      .rd_data (rd_data)
   );

   //////////////////////////////////////////////////////////////////////
   // issue side
   //////////////////////////////////////////////////////////////////////

   snp_issue issue_inst (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .snpq_valid  (snpq_valid),
      .rd_ptr      (rd_ptr),
      .issue_stall (issue_stall),
      .head_hdr1   (head_hdr1),
      .head_hdr2   (head_hdr2),
      .head_data1  (head_data1),
      .head_data2  (head_data2),
      .head_wline  (head_wline),
      .snpsel      (iq_dequeue),
      .free_en     (free_en),
      .free_line   (free_line),
      .iss_vld     (iss_vld),
      .iss_hdr1    (iss_hdr1),
      .iss_hdr2    (iss_hdr2),
      .iss_data1   (iss_data1),
      .iss_data2   (iss_data2),
      .iss_wline   (iss_wline)
   );

endmodule

`default_nettype wire

// File: test/tb_snoop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snoop
   import snp_pkg::*;
();

   logic   rclk;
   logic   rst_n;
   logic   req_vld;
   word_t  req_word;
   logic   issue_stall;
   wline_t rd_line;
   widx_t  rd_idx;
   logic   iq_dequeue;
   logic   iss_vld;
   word_t  iss_hdr1;
   word_t  iss_hdr2;
   word_t  iss_data1;
   word_t  iss_data2;
   wline_t iss_wline;
   word_t  rd_data;

   // flat word list from the stimulus file
   // type column first in each request
   word_t    stim [512];
   int       nreq;
   rq_type_t rq_type  [32];
   int       rq_start [32];
   logic     rq_done  [32];
   wline_t   rq_line  [32];
   // line of another WR64 that held its line while this one was queued
   wline_t   peer_line  [32];
   logic     peer_valid [32];
   logic     used_model [WBUF_LINES];
   logic     line_seen  [WBUF_LINES];

   // requests sent and not yet dequeued with the oldest at the front
   int   sb[$];
   int   credit;
   logic hold_issue;
   logic pend_valid;
   int   pend_req;
   int   deq_count;
   int   issued_count;
   int   reuse_count;

   snoop_top snoop_top_inst (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .req_vld     (req_vld),
      .req_word    (req_word),
      .issue_stall (issue_stall),
      .rd_line     (rd_line),
      .rd_idx      (rd_idx),
      .iq_dequeue  (iq_dequeue),
      .iss_vld     (iss_vld),
      .iss_hdr1    (iss_hdr1),
      .iss_hdr2    (iss_hdr2),
      .iss_data1   (iss_data1),
      .iss_data2   (iss_data2),
      .iss_wline   (iss_wline),
      .rd_data     (rd_data)
   );

   // 4 ns clock
   initial begin
      rclk = 1'b0;
      forever #2 rclk = ~rclk;
   end

   //////////////////////////////////////////////////////////////////////
   // error exits and compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic end_with_failure();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      end_with_failure();
   endtask

   task automatic cmp_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic cmp_line(input string name, input wline_t got, input wline_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus file
   //////////////////////////////////////////////////////////////////////

   task automatic load_stimulus();
      int p;
      $readmemh("test/snoop_stimulus.txt", stim);
      p    = 0;
      nreq = 0;
      // ffffffff in the type column closes the list
      while (stim[p] !== 32'hffff_ffff) begin
         if ($isunknown(stim[p]) || (stim[p] > 32'd2)) begin
            abort_run("stimulus file has a bad type column or no end marker");
         end
         if (stim[p + 1][31:30] != stim[p][1:0]) begin
            abort_run("stimulus type column does not match hdr1 type bits");
         end
         rq_type[nreq]  = rq_type_t'(stim[p][1:0]);
         rq_start[nreq] = p + 1;
         p = p + 1 + ((rq_type[nreq] == RQ_WR64) ? 18 : 4);
         nreq++;
         if ((p >= 480) || (nreq >= 32)) begin
            abort_run("stimulus file holds too many requests");
         end
      end
      if (nreq == 0) begin
         abort_run("stimulus file holds no requests");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // source side with two credits and random pipeline stall
   //////////////////////////////////////////////////////////////////////

   // the tag stage offers the lowest free line
   function automatic wline_t lowest_free();
      wline_t line;
      logic   found;
      line  = '0;
      found = 1'b0;
      for (int i = 0; i < WBUF_LINES; i++) begin
         if (!found && !used_model[i]) begin
            line  = wline_t'(i);
            found = 1'b1;
         end
      end
      return line;
   endfunction

   // a WR64 head waits while a request streams in, so its line is not
   // handed to the request still being received
   function automatic logic pick_stall(input logic busy);
      logic head_wr64;
      head_wr64 = (sb.size() > 0) && (rq_type[sb[0]] == RQ_WR64);
      return hold_issue || (busy && head_wr64) || (($urandom % 8) < 3);
   endfunction

   task automatic send_all();
      int n;
      int waited;
      for (int r = 0; r < nreq; r++) begin
         n      = (rq_type[r] == RQ_WR64) ? 18 : 4;
         waited = 0;
         @(posedge rclk);
         // no new request while a WR64 line is being read back
         while ((credit == 0) || hold_issue) begin
            req_vld     <= 1'b0;
            issue_stall <= pick_stall(1'b0);
            waited++;
            if (waited > 500) begin
               abort_run("no credit came back through iq_dequeue within 500 cycles");
            end
            @(posedge rclk);
         end
         credit--;
         if (rq_type[r] == RQ_WR64) begin
            rq_line[r] = lowest_free();
            used_model[rq_line[r]] = 1'b1;
         end
         sb.push_back(r);
         // words back to back with the strobe on hdr1 only
         for (int k = 0; k < n; k++) begin
            if (k > 0) begin
               @(posedge rclk);
            end
            req_vld     <= (k == 0);
            req_word    <= stim[rq_start[r] + k];
            issue_stall <= pick_stall(1'b1);
         end
         rq_done[r] = 1'b1;
      end
      // stall keeps toggling while the queue drains
      forever begin
         @(posedge rclk);
         req_vld     <= 1'b0;
         issue_stall <= pick_stall(1'b0);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // issue side monitor and scoreboard
   //////////////////////////////////////////////////////////////////////

   // read back the sixteen words of a WR64 line while issue is held
   task automatic check_line(input int r, input wline_t line);
      for (int k = 0; k < WBUF_WORDS; k++) begin
         @(posedge rclk);
         rd_line <= line;
         rd_idx  <= widx_t'(k);
         @(negedge rclk);
         if (iq_dequeue || iss_vld) begin
            abort_run("a request issued while issue_stall was held high");
         end
         cmp_word("rd_data", rd_data, stim[rq_start[r] + 2 + k]);
      end
      hold_issue = 1'b0;
   endtask

   task automatic check_issue(input int r);
      issued_count++;
      cmp_word("iss_hdr1", iss_hdr1, stim[rq_start[r]]);
      cmp_word("iss_hdr2", iss_hdr2, stim[rq_start[r] + 1]);
      if (rq_type[r] != RQ_WR64) begin
         cmp_word("iss_data1", iss_data1, stim[rq_start[r] + 2]);
         cmp_word("iss_data2", iss_data2, stim[rq_start[r] + 3]);
      end else begin
         if (peer_valid[r] && (iss_wline == peer_line[r])) begin
            abort_run("two outstanding WR64 requests were given the same buffer line");
         end
         cmp_line("iss_wline", iss_wline, rq_line[r]);
         if (line_seen[iss_wline]) begin
            reuse_count++;
         end
         line_seen[iss_wline] = 1'b1;
         // fully received WR64s still queued hold a line besides this one
         foreach (sb[i]) begin
            if ((rq_type[sb[i]] == RQ_WR64) && rq_done[sb[i]]) begin
               peer_line[sb[i]]  = iss_wline;
               peer_valid[sb[i]] = 1'b1;
            end
         end
         check_line(r, iss_wline);
      end
   endtask

   task automatic watch_outputs();
      logic deq_now;
      int   r;
      forever begin
         @(negedge rclk);
         if ($isunknown({iq_dequeue, iss_vld})) begin
            abort_run("iq_dequeue or iss_vld is unknown");
         end
         deq_now = iq_dequeue;
         // iss_vld exactly one cycle after each dequeue
         if (pend_valid) begin
            if (!iss_vld) begin
               abort_run("iss_vld did not follow iq_dequeue one cycle later");
            end
            pend_valid = 1'b0;
            check_issue(pend_req);
         end else if (iss_vld) begin
            abort_run("iss_vld rose without a dequeue in the cycle before");
         end
         if (deq_now) begin
            if (sb.size() == 0) begin
               abort_run("iq_dequeue pulsed with no request outstanding");
            end
            r = sb.pop_front();
            if (!rq_done[r]) begin
               abort_run("iq_dequeue pulsed before the request was fully received");
            end
            if (rq_type[r] == RQ_WR64) begin
               hold_issue = 1'b1;
               used_model[rq_line[r]] = 1'b0;
            end
            credit++;
            deq_count++;
            pend_req   = r;
            pend_valid = 1'b1;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int idle;
      int last_issued;
      rst_n       = 1'b0;
      req_vld     = 1'b0;
      req_word    = '0;
      issue_stall = 1'b0;
      rd_line     = '0;
      rd_idx      = '0;
      credit       = 2;
      hold_issue   = 1'b0;
      pend_valid   = 1'b0;
      pend_req     = 0;
      deq_count    = 0;
      issued_count = 0;
      reuse_count  = 0;
      for (int i = 0; i < 32; i++) begin
         rq_done[i]    = 1'b0;
         peer_valid[i] = 1'b0;
      end
      for (int i = 0; i < WBUF_LINES; i++) begin
         used_model[i] = 1'b0;
         line_seen[i]  = 1'b0;
      end
      load_stimulus();

      repeat (5) @(posedge rclk);
      rst_n <= 1'b1;
      void'($urandom(32'he47a));

      fork
         send_all();
         watch_outputs();
      join_none

      // wait until every request has issued with no long gap between issues
      idle        = 0;
      last_issued = 0;
      while (issued_count < nreq) begin
         @(posedge rclk);
         if (issued_count != last_issued) begin
            last_issued = issued_count;
            idle        = 0;
         end else begin
            idle++;
         end
         if (idle > 500) begin
            abort_run("no request was issued within 500 cycles");
         end
      end
      // stray dequeues would show up here
      repeat (20) @(posedge rclk);

      if ((deq_count != nreq) || (sb.size() != 0)) begin
         abort_run("iq_dequeue count differs from the number of requests");
      end else if (reuse_count == 0) begin
         abort_run("no buffer line was reused after its WR64 issued");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: test/snoop_stimulus.txt
// columns: type (0 RD, 1 WR8, 2 WR64), hdr1, hdr2, then data words
// a WR64 has its sixteen data words on the two lines after it, ffffffff ends the list
0 00001000 11110000 d0000001 d0000002
2 80002040 22220000
a5d10000 a5d10001 a5d10002 a5d10003 a5d10004 a5d10005 a5d10006 a5d10007
a5d10008 a5d10009 a5d1000a a5d1000b a5d1000c a5d1000d a5d1000e a5d1000f
1 40003008 33330000 d0000011 d0000012
2 80004040 44440000
b6e20000 b6e20001 b6e20002 b6e20003 b6e20004 b6e20005 b6e20006 b6e20007
b6e20008 b6e20009 b6e2000a b6e2000b b6e2000c b6e2000d b6e2000e b6e2000f
2 80005040 55550000
c7f30000 c7f30001 c7f30002 c7f30003 c7f30004 c7f30005 c7f30006 c7f30007
c7f30008 c7f30009 c7f3000a c7f3000b c7f3000c c7f3000d c7f3000e c7f3000f
0 00006000 66660000 d0000021 d0000022
1 40007008 77770000 d0000031 d0000032
2 80008040 88880000
e8040000 e8040001 e8040002 e8040003 e8040004 e8040005 e8040006 e8040007
e8040008 e8040009 e804000a e804000b e804000c e804000d e804000e e804000f
0 00009000 99990000 d0000041 d0000042
1 4000a008 aaaa0000 d0000051 d0000052
ffffffff

// File: files.f
hdl/snp_pkg.sv
hdl/snp_wr_if.sv
hdl/snp_iq_ctl.sv
hdl/snp_iq_data.sv
hdl/rdma_tag.sv
hdl/rdma_wbuf.sv
hdl/snp_issue.sv
hdl/snoop_top.sv
test/tb_snoop.sv

// File: run.sh
#!/bin/sh
# build and run the snoop path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_snoop \
   -f files.f -o Vtb_snoop

# a $fatal in the testbench gives a failing exit status
./obj_dir/Vtb_snoop
